// ==== Makefile ====
VERILATOR ?= verilator
TOP ?= tb_ymp_sound_core
FILELIST ?= files.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
PASS_MSG ?= Done: no errors

.PHONY: sim clean

# build, run, then look for the pass line in the log
sim:
	$(VERILATOR) --binary --timing --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qxF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
rtl/ymp_pkg.sv
rtl/ymp_sync_ram.sv
rtl/ymp_bus_decoder.sv
rtl/ymp_host_control.sv
rtl/ymp_sigma_delta_dac.sv
rtl/ymp_sound_core.sv
verification/ymp_clock_gen.sv
verification/tb_ymp_sound_core.sv

// ==== rtl/ymp_bus_decoder.sv ====
module ymp_bus_decoder import ymp_pkg::*; (
	input  logic       clk_per,
	input  logic       rst_n,
	input  cpu_bus_t   cpu_bus,
	input  logic [7:0] rom_rdata,
	input  logic [7:0] ram_rdata,
	input  logic [7:0] opm_rdata,
	input  logic [7:0] latch,
	output logic       ram_we,
	output logic       latch_rd,
	output opm_bus_t   opm_bus,
	output logic [7:0] cpu_rdata
);

	logic rom_sel;
	logic ram_sel;
	logic latch_sel;
	logic opm_sel;
	logic rd_cycle;

	// source of the read issued one cycle earlier
	logic rom_q;
	logic ram_q;
	logic latch_q;
	logic opm_q;

	logic [7:0] latch_data_q;
	logic [7:0] opm_data_q;

	// rom mirrors over the whole upper half
	assign rom_sel = cpu_bus.vma && cpu_bus.addr[15];
	assign ram_sel = cpu_bus.vma && (cpu_bus.addr[15:RAM_AW] == '0);
	assign latch_sel = cpu_bus.vma && (cpu_bus.addr == LATCH_ADDR);
	assign opm_sel = cpu_bus.vma && (cpu_bus.addr[15:1] == OPM_BASE[15:1]);
	assign rd_cycle = cpu_bus.rw;

	assign ram_we = ram_sel && !cpu_bus.rw;
	assign latch_rd = latch_sel && rd_cycle;

	assign opm_bus.cs_n = !opm_sel;
	assign opm_bus.a0 = cpu_bus.addr[0];
	assign opm_bus.wr_n = !(opm_sel && !cpu_bus.rw);
	assign opm_bus.data = cpu_bus.wdata;

	always_ff @(posedge clk_per) begin
		if (!rst_n) begin
			rom_q <= 1'b0;
			ram_q <= 1'b0;
			latch_q <= 1'b0;
			opm_q <= 1'b0;
		end else begin
			rom_q <= rom_sel && rd_cycle;
			ram_q <= ram_sel && rd_cycle;
			latch_q <= latch_rd;
			opm_q <= opm_sel && rd_cycle;
		end
	end

	// combinational latch and opm data delayed like the memories
	always_ff @(posedge clk_per) begin
		latch_data_q <= latch;
		opm_data_q <= opm_rdata;
	end

	// nothing selected last cycle means open bus
	always_comb begin
		if (rom_q) begin
			cpu_rdata = rom_rdata;
		end else if (ram_q) begin
			cpu_rdata = ram_rdata;
		end else if (latch_q) begin
			cpu_rdata = latch_data_q;
		end else if (opm_q) begin
			cpu_rdata = opm_data_q;
		end else begin
			cpu_rdata = OPEN_BUS;
		end
	end

endmodule

// ==== rtl/ymp_host_control.sv ====
module ymp_host_control import ymp_pkg::*; (
	input  logic       clk_per,
	input  logic       rst_n,
	input  host_byte_t host_in,
	input  logic       prog_mode,
	input  logic       latch_rd,
	output rom_write_t rom_wr,
	output logic [7:0] latch,
	output logic       irq,
	output logic       cpu_rst,
	output logic [7:0] led
);

	logic prog_q;
	logic prog_rise;

	logic [ROM_AW-1:0] load_addr;
	logic [ROM_AW-1:0] cur_addr;

	logic              wr_q;
	logic [ROM_AW-1:0] waddr_q;
	logic [7:0]        wdata_q;

	assign prog_rise = prog_mode && !prog_q;

	// a byte on the rising edge itself goes to address 0
	assign cur_addr = prog_rise ? '0 : load_addr;

	// cpu held in reset one cycle past the end of programming
	assign cpu_rst = prog_mode || prog_q;

	always_ff @(posedge clk_per) begin
		if (!rst_n) begin
			prog_q <= 1'b0;
			load_addr <= '0;
			wr_q <= 1'b0;
		end else begin
			prog_q <= prog_mode;
			wr_q <= prog_mode && host_in.valid;
			if (prog_mode && host_in.valid) begin
				load_addr <= cur_addr + 1'b1;
			end else if (prog_rise) begin
				load_addr <= '0;
			end
		end
	end

	always_ff @(posedge clk_per) begin
		if (prog_mode && host_in.valid) begin
			waddr_q <= cur_addr;
			wdata_q <= host_in.data;
		end
	end

	assign rom_wr.wr = wr_q;
	assign rom_wr.addr = waddr_q;
	assign rom_wr.data = wdata_q;

	// a new host byte beats a clearing latch read
	always_ff @(posedge clk_per) begin
		if (!rst_n) begin
			latch <= '0;
			irq <= 1'b0;
		end else if (!prog_mode && host_in.valid) begin
			latch <= host_in.data;
			irq <= 1'b1;
		end else if (latch_rd) begin
			irq <= 1'b0;
		end
	end

	// loader progress while programming
	assign led = prog_mode ? load_addr[ROM_AW-1 -: 8] : latch;

endmodule

// ==== rtl/ymp_pkg.sv ====
package ymp_pkg;

	// memory map
	localparam int ROM_AW = 12;
	localparam int RAM_AW = 11;
	localparam logic [15:0] LATCH_ADDR = 16'h1000;
	localparam logic [15:0] OPM_BASE = 16'h2000;
	localparam logic [7:0] OPEN_BUS = 8'hff;

	// sample width into the modulators
	localparam int DAC_W = 16;

	// one sound cpu bus cycle
	typedef struct packed {
		logic [15:0] addr;
		logic [7:0]  wdata;
		logic        rw;
		logic        vma;
	} cpu_bus_t;

	// opm register port with active-low strobes
	typedef struct packed {
		logic       cs_n;
		logic       a0;
		logic       wr_n;
		logic [7:0] data;
	} opm_bus_t;

	typedef struct packed {
		logic       valid;
		logic [7:0] data;
	} host_byte_t;

	// loader write into program rom
	typedef struct packed {
		logic              wr;
		logic [ROM_AW-1:0] addr;
		logic [7:0]        data;
	} rom_write_t;

	typedef struct packed {
		logic signed [DAC_W-1:0] left;
		logic signed [DAC_W-1:0] right;
	} stereo_sample_t;

endpackage

// ==== rtl/ymp_sigma_delta_dac.sv ====
module ymp_sigma_delta_dac import ymp_pkg::*; (
	input  logic                    clk_per,
	input  logic                    rst_n,
	input  logic signed [DAC_W-1:0] sample,
	output logic                    bit_out
);

	logic [DAC_W-1:0] u;
	logic [DAC_W-1:0] acc;
	logic [DAC_W:0]   sum;

	// offset binary by flipping the sign bit, i.e. adding half scale
	assign u = {~sample[DAC_W-1], sample[DAC_W-2:0]};

	assign sum = {1'b0, acc} + {1'b0, u};

	// carry out of the accumulator is the density bit
	always_ff @(posedge clk_per) begin
		if (!rst_n) begin
			acc <= '0;
			bit_out <= 1'b0;
		end else begin
			acc <= sum[DAC_W-1:0];
			bit_out <= sum[DAC_W];
		end
	end

endmodule

// ==== rtl/ymp_sound_core.sv ====
module ymp_sound_core import ymp_pkg::*; (
	input  logic           clk_per,
	input  logic           rst_n,
	input  cpu_bus_t       cpu_bus,
	output logic [7:0]     cpu_rdata,
	output logic           irq,
	output logic           cpu_rst,
	output opm_bus_t       opm_bus,
	input  logic [7:0]     opm_rdata,
	input  stereo_sample_t opm_sample,
	input  logic           sample_valid,
	input  host_byte_t     host_in,
	input  logic           prog_mode,
	output logic [7:0]     led,
	output logic           speaker_left,
	output logic           speaker_right
);

	rom_write_t rom_wr;
	logic [ROM_AW-1:0] rom_addr;
	logic [7:0] rom_rdata;
	logic [7:0] ram_rdata;
	logic [7:0] latch;
	logic ram_we;
	logic latch_rd;
	stereo_sample_t dac_sample;

	// loader keeps the rom port until its write after prog_mode falls
	assign rom_addr = (prog_mode || rom_wr.wr) ? rom_wr.addr : cpu_bus.addr[ROM_AW-1:0];

	ymp_sync_ram #(
		.ADDR_W(ROM_AW)
	) i_rom (
		.clk_per(clk_per),
		.addr(rom_addr),
		.we(rom_wr.wr),
		.wdata(rom_wr.data),
		.rdata(rom_rdata)
	);

	ymp_sync_ram #(
		.ADDR_W(RAM_AW)
	) i_ram (
		.clk_per(clk_per),
		.addr(cpu_bus.addr[RAM_AW-1:0]),
		.we(ram_we),
		.wdata(cpu_bus.wdata),
		.rdata(ram_rdata)
	);

	ymp_bus_decoder i_bus_decoder (
		.clk_per(clk_per),
		.rst_n(rst_n),
		.cpu_bus(cpu_bus),
		.rom_rdata(rom_rdata),
		.ram_rdata(ram_rdata),
		.opm_rdata(opm_rdata),
		.latch(latch),
		.ram_we(ram_we),
		.latch_rd(latch_rd),
		.opm_bus(opm_bus),
		.cpu_rdata(cpu_rdata)
	);

	ymp_host_control i_host_control (
		.clk_per(clk_per),
		.rst_n(rst_n),
		.host_in(host_in),
		.prog_mode(prog_mode),
		.latch_rd(latch_rd),
		.rom_wr(rom_wr),
		.latch(latch),
		.irq(irq),
		.cpu_rst(cpu_rst),
		.led(led)
	);

	// hold the last opm sample for both modulators
	always_ff @(posedge clk_per) begin
		if (!rst_n) begin
			dac_sample <= '0;
		end else if (sample_valid) begin
			dac_sample <= opm_sample;
		end
	end

	ymp_sigma_delta_dac i_dac_left (
		.clk_per(clk_per),
		.rst_n(rst_n),
		.sample(dac_sample.left),
		.bit_out(speaker_left)
	);

	ymp_sigma_delta_dac i_dac_right (
		.clk_per(clk_per),
		.rst_n(rst_n),
		.sample(dac_sample.right),
		.bit_out(speaker_right)
	);

endmodule

// ==== rtl/ymp_sync_ram.sv ====
module ymp_sync_ram #(
	parameter int ADDR_W = 8
) (
	input  logic              clk_per,
	input  logic [ADDR_W-1:0] addr,
	input  logic              we,
	input  logic [7:0]        wdata,
	output logic [7:0]        rdata
);

	localparam int DEPTH = 2 ** ADDR_W;

	logic [7:0] mem [DEPTH];

	// read-first so a write shows up on the next read of that address
	always_ff @(posedge clk_per) begin
		if (we) begin
			mem[addr] <= wdata;
		end
		rdata <= mem[addr];
	end

endmodule

// ==== verification/tb_ymp_sound_core.sv ====
module tb_ymp_sound_core import ymp_pkg::*; ();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int DAC_WINDOW = 4096;
	// four times the length of four dac windows and about 600 bus cycles
	localparam int TIMEOUT_CYCLES = 4 * (4 * (DAC_WINDOW + 2) + 600);

	logic clk_per;
	logic rst_n;
	cpu_bus_t cpu_bus;
	logic [7:0] cpu_rdata;
	logic irq;
	logic cpu_rst;
	opm_bus_t opm_bus;
	logic [7:0] opm_rdata;
	stereo_sample_t opm_sample;
	logic sample_valid;
	host_byte_t host_in;
	logic prog_mode;
	logic [7:0] led;
	logic speaker_left;
	logic speaker_right;

	integer seed = 65;
	int cycle_count;
	int n_checks;
	int byte_errors;
	int opm_errors;
	int bit_errors;
	int density_errors;
	logic [7:0] rom_image [64];

	ymp_clock_gen i_clock_gen (
		.clk_per(clk_per),
		.rst_n(rst_n)
	);

	ymp_sound_core i_dut (
		.clk_per(clk_per),
		.rst_n(rst_n),
		.cpu_bus(cpu_bus),
		.cpu_rdata(cpu_rdata),
		.irq(irq),
		.cpu_rst(cpu_rst),
		.opm_bus(opm_bus),
		.opm_rdata(opm_rdata),
		.opm_sample(opm_sample),
		.sample_valid(sample_valid),
		.host_in(host_in),
		.prog_mode(prog_mode),
		.led(led),
		.speaker_left(speaker_left),
		.speaker_right(speaker_right)
	);

	task automatic check_byte(input string what, input logic [7:0] got, input logic [7:0] exp);
		n_checks++;
		if (got !== exp) begin
			byte_errors++;
			$display("Error at %0t: %s is %h, expected %h", $time, what, got, exp);
		end
	endtask

	task automatic check_opm(input string what, input opm_bus_t got, input opm_bus_t exp);
		n_checks++;
		if (got !== exp) begin
			opm_errors++;
			$display("Error at %0t: %s is cs_n=%b a0=%b wr_n=%b data=%h, expected %b %b %b %h",
				$time, what, got.cs_n, got.a0, got.wr_n, got.data,
				exp.cs_n, exp.a0, exp.wr_n, exp.data);
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		n_checks++;
		if (got !== exp) begin
			bit_errors++;
			$display("Error at %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	// ones over the window must be within one of window * u / 65536
	task automatic check_density(input string what, input int ones,
		input logic signed [15:0] sample);
		int u;
		int diff;
		u = int'(sample) + 32768;
		diff = ones * 65536 - DAC_WINDOW * u;
		n_checks++;
		if (diff < -65536 || diff > 65536) begin
			density_errors++;
			$display("Error at %0t: %s counted %0d ones for sample %0d, expected about %0d",
				$time, what, ones, sample, (DAC_WINDOW * u) / 65536);
		end
	endtask

	task automatic next_cycle();
		@(posedge clk_per);
		#1;
	endtask

	task automatic bus_idle();
		cpu_bus.addr = '0;
		cpu_bus.wdata = '0;
		cpu_bus.rw = 1'b1;
		cpu_bus.vma = 1'b0;
	endtask

	task automatic cpu_read(input logic [15:0] addr);
		cpu_bus.addr = addr;
		cpu_bus.wdata = '0;
		cpu_bus.rw = 1'b1;
		cpu_bus.vma = 1'b1;
	endtask

	task automatic cpu_write(input logic [15:0] addr, input logic [7:0] data);
		cpu_bus.addr = addr;
		cpu_bus.wdata = data;
		cpu_bus.rw = 1'b0;
		cpu_bus.vma = 1'b1;
	endtask

	// data for the read comes back on the following cycle
	task automatic read_check(input string what, input logic [15:0] addr, input logic [7:0] exp);
		cpu_read(addr);
		next_cycle();
		bus_idle();
		check_byte($sformatf("%s at %h", what, addr), cpu_rdata, exp);
	endtask

	task automatic host_send(input logic [7:0] data);
		host_in.valid = 1'b1;
		host_in.data = data;
		next_cycle();
		host_in.valid = 1'b0;
	endtask

	task automatic test_reset_values();
		repeat (4) next_cycle();
		check_bit("irq in reset", irq, 1'b0);
		check_bit("cpu_rst in reset", cpu_rst, 1'b0);
		check_bit("speaker_left in reset", speaker_left, 1'b0);
		check_bit("speaker_right in reset", speaker_right, 1'b0);
		check_bit("opm cs_n in reset", opm_bus.cs_n, 1'b1);
		check_bit("opm wr_n in reset", opm_bus.wr_n, 1'b1);
		check_byte("led with latch in reset", led, 8'h00);
		wait (rst_n === 1'b1);
		next_cycle();
	endtask

	task automatic test_rom_program();
		prog_mode = 1'b1;
		next_cycle();
		check_bit("cpu_rst while programming", cpu_rst, 1'b1);
		check_byte("led at loader start", led, 8'h00);
		for (int i = 0; i < 64; i++) begin
			rom_image[i] = 8'($random(seed));
			host_send(rom_image[i]);
			check_byte("led during load", led, 8'((i + 1) >> 4));
		end
		prog_mode = 1'b0;
		#1;
		check_bit("cpu_rst one cycle after programming", cpu_rst, 1'b1);
		next_cycle();
		check_bit("cpu_rst released", cpu_rst, 1'b0);
		for (int i = 0; i < 64; i++) begin
			read_check("rom read", 16'h8000 + 16'(i), rom_image[i]);
		end
		// upper half mirrors the 4 KB image
		for (int i = 0; i < 64; i++) begin
			read_check("rom mirror read", 16'h9000 + 16'(i), rom_image[i]);
		end
	endtask

	task automatic test_ram();
		logic [10:0] base;
		logic [15:0] addr;
		logic [7:0] data;
		logic [7:0] written [16];
		base = 11'($random(seed));
		for (int i = 0; i < 16; i++) begin
			addr = {5'b0, base + 11'(i * 67)};
			data = 8'($random(seed));
			written[i] = data;
			cpu_write(addr, data);
			next_cycle();
			read_check("ram read", addr, data);
		end
		// each address still holds its own byte
		for (int i = 0; i < 16; i++) begin
			addr = {5'b0, base + 11'(i * 67)};
			read_check("ram read back", addr, written[i]);
		end
		read_check("open bus", 16'h0800, OPEN_BUS);
		read_check("open bus", 16'h0c5a, OPEN_BUS);
		read_check("open bus", 16'h0fff, OPEN_BUS);
		read_check("open bus", 16'h3000, OPEN_BUS);
	endtask

	task automatic test_latch_irq();
		logic [7:0] first;
		logic [7:0] second;
		first = 8'($random(seed));
		second = ~first;
		check_bit("irq before host byte", irq, 1'b0);
		host_send(first);
		check_bit("irq after host byte", irq, 1'b1);
		check_byte("led with latch", led, first);
		read_check("latch read", LATCH_ADDR, first);
		check_bit("irq after latch read", irq, 1'b0);
		host_send(first);
		// new byte in the same cycle as the clearing read
		cpu_read(LATCH_ADDR);
		host_send(second);
		bus_idle();
		check_byte("latch read during new byte", cpu_rdata, first);
		check_bit("irq kept by new byte", irq, 1'b1);
		check_byte("led after collision", led, second);
		read_check("latch read after collision", LATCH_ADDR, second);
		check_bit("irq after second read", irq, 1'b0);
	endtask

	task automatic test_opm_port();
		opm_bus_t expected;
		logic [7:0] data;
		data = 8'($random(seed));
		cpu_write(OPM_BASE + 16'd1, data);
		#1;
		expected.cs_n = 1'b0;
		expected.a0 = 1'b1;
		expected.wr_n = 1'b0;
		expected.data = data;
		check_opm("opm data write", opm_bus, expected);
		next_cycle();
		opm_rdata = 8'($random(seed));
		cpu_read(OPM_BASE);
		#1;
		check_bit("opm cs_n on read", opm_bus.cs_n, 1'b0);
		check_bit("opm a0 on read", opm_bus.a0, 1'b0);
		check_bit("opm wr_n on read", opm_bus.wr_n, 1'b1);
		next_cycle();
		bus_idle();
		check_byte("opm read data", cpu_rdata, opm_rdata);
		// write-shaped cycle with vma low
		cpu_bus.addr = OPM_BASE;
		cpu_bus.rw = 1'b0;
		#1;
		check_bit("opm cs_n without vma", opm_bus.cs_n, 1'b1);
		check_bit("opm wr_n without vma", opm_bus.wr_n, 1'b1);
		next_cycle();
		bus_idle();
	endtask

	task automatic measure_dac(input logic signed [15:0] left, input logic signed [15:0] right);
		int ones_left;
		int ones_right;
		ones_left = 0;
		ones_right = 0;
		opm_sample.left = left;
		opm_sample.right = right;
		sample_valid = 1'b1;
		next_cycle();
		sample_valid = 1'b0;
		// first carry from the new sample shows one cycle after the load
		next_cycle();
		repeat (DAC_WINDOW) begin
			if (speaker_left) begin
				ones_left++;
			end
			if (speaker_right) begin
				ones_right++;
			end
			next_cycle();
		end
		check_density("speaker_left density", ones_left, left);
		check_density("speaker_right density", ones_right, right);
	endtask

	task automatic test_dac_density();
		logic signed [15:0] levels [4];
		levels[0] = 16'sh8000;
		levels[1] = 16'sh0000;
		levels[2] = 16'sh4000;
		levels[3] = 16'($random(seed));
		for (int k = 0; k < 4; k++) begin
			measure_dac(levels[k], levels[3 - k]);
		end
	endtask

	initial begin
		cpu_bus = '0;
		opm_rdata = '0;
		opm_sample = '0;
		sample_valid = 1'b0;
		host_in = '0;
		prog_mode = 1'b0;
		n_checks = 0;
		byte_errors = 0;
		opm_errors = 0;
		bit_errors = 0;
		density_errors = 0;
		test_reset_values();
		test_rom_program();
		test_ram();
		test_latch_irq();
		test_opm_port();
		test_dac_density();
		$display("Checks: %0d, errors: byte %0d, opm %0d, bit %0d, density %0d",
			n_checks, byte_errors, opm_errors, bit_errors, density_errors);
		if (byte_errors + opm_errors + bit_errors + density_errors == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

	initial begin
		cycle_count = 0;
		while (cycle_count < TIMEOUT_CYCLES) begin
			@(posedge clk_per);
			cycle_count++;
		end
		$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Done: errors found");
		$finish;
	end

endmodule

// ==== verification/ymp_clock_gen.sv ====
module ymp_clock_gen (
	output logic clk_per,
	output logic rst_n
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int HALF_PERIOD = 4;
	localparam int RESET_CYCLES = 16;

	initial begin
		clk_per = 1'b0;
		forever #(HALF_PERIOD) clk_per = ~clk_per;
	end

	// release just after the last reset edge
	initial begin
		rst_n = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk_per);
		#1 rst_n = 1'b1;
	end

endmodule
